//--- design/lsu_pkg.sv
package lsu_pkg;

    // byte address as seen by the core
    typedef logic [63:0] addr_t;

    // one RAM row, also store data and load result
    typedef logic [63:0] data_t;

    // one enable bit per byte lane of a row
    typedef logic [7:0] mask_t;

    // RISC-V load/store funct3
    // bits 1:0 give the width, bit 2 marks an unsigned load
    typedef logic [2:0] funct3_t;

    // access width code
    typedef logic [1:0] width_t;

    // byte position inside a row
    typedef logic [2:0] offset_t;

    // width codes, 1, 2, 4 and 8 bytes
    localparam width_t width_b = 2'd0;
    localparam width_t width_h = 2'd1;
    localparam width_t width_w = 2'd2;
    localparam width_t width_d = 2'd3;

    // bytes per RAM row
    localparam int row_bytes = 8;

    // lane enables for an access at offset 0
    localparam mask_t lanes_b = 8'h01;
    localparam mask_t lanes_h = 8'h03;
    localparam mask_t lanes_w = 8'h0f;
    localparam mask_t lanes_d = 8'hff;

endpackage

//--- design/mem_req_if.sv
`timescale 1ns/1ns

// decoded request, decode to RAM
interface mem_req_if import lsu_pkg::*; #(
    parameter int depth_log2 = 6
) ();

    logic wr_en;
    logic rd_en;
    logic fault;
    logic [depth_log2-1:0] row;
    mask_t byte_mask;
    data_t wr_row;
    offset_t offset;
    width_t width;
    logic is_unsigned;

    modport source (
        output wr_en, rd_en, fault, row, byte_mask, wr_row,
        output offset, width, is_unsigned
    );

    modport sink (
        input wr_en, rd_en, fault, row, byte_mask, wr_row,
        input offset, width, is_unsigned
    );

endinterface

//--- design/mem_rsp_if.sv
`timescale 1ns/1ns

// registered row plus load attributes, RAM to result
interface mem_rsp_if import lsu_pkg::*; ();

    logic valid;
    logic fault;
    data_t row_data;
    offset_t offset;
    width_t width;
    logic is_unsigned;

    modport source (
        output valid, fault, row_data, offset, width, is_unsigned
    );

    modport sink (
        input valid, fault, row_data, offset, width, is_unsigned
    );

endinterface

//--- design/lsu_decode.sv
`timescale 1ns/1ns

module lsu_decode import lsu_pkg::*; #(
    parameter addr_t ram_base = 64'h8000_0000,
    parameter int depth_log2 = 6
) (
    input funct3_t funct3,
    input addr_t addr,
    input data_t wdata,
    input logic ren,
    input logic wen,
    mem_req_if.source req
);

    width_t width;
    offset_t offset;
    addr_t rel_addr;
    logic aligned;
    mask_t lane_pattern;

    assign width = width_t'(funct3[1:0]);
    assign offset = offset_t'(addr[2:0]);

    // address relative to the start of the RAM
    assign rel_addr = addr - ram_base;

    // natural alignment from the low address bits
    always_comb begin
        case (width)
            width_b: aligned = 1'b1;
            width_h: aligned = (addr[0] == 1'b0);
            width_w: aligned = (addr[1:0] == 2'b00);
            default: aligned = (addr[2:0] == 3'b000);
        endcase
    end

    // lane pattern and store data copied into every slot of its width
    always_comb begin
        case (width)
            width_b: begin
                lane_pattern = lanes_b;
                req.wr_row = {8{wdata[7:0]}};
            end
            width_h: begin
                lane_pattern = lanes_h;
                req.wr_row = {4{wdata[15:0]}};
            end
            width_w: begin
                lane_pattern = lanes_w;
                req.wr_row = {2{wdata[31:0]}};
            end
            default: begin
                lane_pattern = lanes_d;
                req.wr_row = wdata;
            end
        endcase
    end

    // the mask picks the one slot that is really written
    assign req.byte_mask = lane_pattern << offset;

    // row index wraps modulo the RAM depth
    assign req.row = rel_addr[depth_log2+2:3];

    // write wins over read, misaligned requests do nothing
    assign req.wr_en = wen & aligned;
    assign req.rd_en = ren & ~wen & aligned;
    assign req.fault = (ren | wen) & ~aligned;

    assign req.offset = offset;
    assign req.width = width;
    assign req.is_unsigned = funct3[2];

endmodule

//--- design/lsu_ram.sv
`timescale 1ns/1ns

module lsu_ram import lsu_pkg::*; #(
    parameter int depth_log2 = 6
) (
    input logic clk,
    input logic reset,
    mem_req_if.sink req,
    mem_rsp_if.source rsp
);

    localparam int rows = 1 << depth_log2;

    data_t ram [0:rows-1];

    // byte lane writes on the rising edge
    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            for (int i = 0; i < row_bytes; i++) begin
                if (req.byte_mask[i]) begin
                    ram[req.row][i*8 +: 8] <= req.wr_row[i*8 +: 8];
                end
            end
        end
    end

    // synchronous read, attributes travel with the row
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            rsp.row_data <= ram[req.row];
            rsp.offset <= req.offset;
            rsp.width <= req.width;
            rsp.is_unsigned <= req.is_unsigned;
        end
    end

    // one-cycle status pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid <= 1'b0;
            rsp.fault <= 1'b0;
        end else begin
            rsp.valid <= req.rd_en;
            rsp.fault <= req.fault;
        end
    end

endmodule

//--- design/lsu_load_align.sv
`timescale 1ns/1ns

module lsu_load_align import lsu_pkg::*; (
    mem_rsp_if.sink rsp,
    output data_t rdata,
    output logic rvalid,
    output logic fault
);

    data_t shifted;
    logic sign_bit;

    // addressed byte moved down to lane 0
    assign shifted = rsp.row_data >> {rsp.offset, 3'b000};

    // pick the field and extend it
    always_comb begin
        case (rsp.width)
            width_b: begin
                sign_bit = shifted[7] & ~rsp.is_unsigned;
                rdata = {{56{sign_bit}}, shifted[7:0]};
            end
            width_h: begin
                sign_bit = shifted[15] & ~rsp.is_unsigned;
                rdata = {{48{sign_bit}}, shifted[15:0]};
            end
            width_w: begin
                sign_bit = shifted[31] & ~rsp.is_unsigned;
                rdata = {{32{sign_bit}}, shifted[31:0]};
            end
            default: begin
                // full row, nothing to extend
                sign_bit = 1'b0;
                rdata = shifted;
            end
        endcase
    end

    assign rvalid = rsp.valid;
    assign fault = rsp.fault;

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; #(
    parameter addr_t ram_base = 64'h8000_0000,
    parameter int depth_log2 = 6
) (
    input logic clk,
    input logic reset,
    input logic ren,
    input logic wen,
    input addr_t addr,
    input data_t wdata,
    input funct3_t funct3,
    output data_t rdata,
    output logic rvalid,
    output logic fault
);

    mem_req_if #(
        .depth_log2(depth_log2)
    ) req_if ();

    mem_rsp_if rsp_if ();

    // decode
    lsu_decode #(
        .ram_base(ram_base),
        .depth_log2(depth_log2)
    ) lsu_decode_inst (
        .funct3(funct3),
        .addr(addr),
        .wdata(wdata),
        .ren(ren),
        .wen(wen),
        .req(req_if.source)
    );

    // execute
    lsu_ram #(
        .depth_log2(depth_log2)
    ) lsu_ram_inst (
        .clk(clk),
        .reset(reset),
        .req(req_if.sink),
        .rsp(rsp_if.source)
    );

    // result
    lsu_load_align lsu_load_align_inst (
        .rsp(rsp_if.sink),
        .rdata(rdata),
        .rvalid(rvalid),
        .fault(fault)
    );

endmodule

//--- sim/lsu_tb_vectors.svh
`ifndef LSU_TB_VECTORS_SVH
`define LSU_TB_VECTORS_SVH

    // name, ren, wen, funct3, addr, wdata, then rvalid, rdata, fault one cycle later
    task automatic fill_vectors();
        // double round trip in row 0
        add_vec("sd_row0", 0, 1, 3'd3, 64'h8000_0000, 64'h0123_4567_89ab_cdef, 0, 64'h0, 0);
        add_vec("ld_row0", 1, 0, 3'd3, 64'h8000_0000, 64'h0, 1, 64'h0123_4567_89ab_cdef, 0);
        // byte and half stores into a written row
        add_vec("sd_row1", 0, 1, 3'd3, 64'h8000_0008, 64'h1122_3344_5566_7788, 0, 64'h0, 0);
        add_vec("sb_lane2", 0, 1, 3'd0, 64'h8000_000a, 64'haa, 0, 64'h0, 0);
        add_vec("sh_lane6", 0, 1, 3'd1, 64'h8000_000e, 64'hbeef, 0, 64'h0, 0);
        add_vec("ld_row1", 1, 0, 3'd3, 64'h8000_0008, 64'h0, 1, 64'hbeef_3344_55aa_7788, 0);
        // every byte of row 2 has its top bit set
        add_vec("sd_row2", 0, 1, 3'd3, 64'h8000_0010, 64'hf0e1_d2c3_b4a5_9687, 0, 64'h0, 0);
        add_vec("lb_off0", 1, 0, 3'd0, 64'h8000_0010, 64'h0, 1, 64'hffff_ffff_ffff_ff87, 0);
        add_vec("lb_off1", 1, 0, 3'd0, 64'h8000_0011, 64'h0, 1, 64'hffff_ffff_ffff_ff96, 0);
        add_vec("lb_off2", 1, 0, 3'd0, 64'h8000_0012, 64'h0, 1, 64'hffff_ffff_ffff_ffa5, 0);
        add_vec("lb_off3", 1, 0, 3'd0, 64'h8000_0013, 64'h0, 1, 64'hffff_ffff_ffff_ffb4, 0);
        add_vec("lb_off4", 1, 0, 3'd0, 64'h8000_0014, 64'h0, 1, 64'hffff_ffff_ffff_ffc3, 0);
        add_vec("lb_off5", 1, 0, 3'd0, 64'h8000_0015, 64'h0, 1, 64'hffff_ffff_ffff_ffd2, 0);
        add_vec("lb_off6", 1, 0, 3'd0, 64'h8000_0016, 64'h0, 1, 64'hffff_ffff_ffff_ffe1, 0);
        add_vec("lb_off7", 1, 0, 3'd0, 64'h8000_0017, 64'h0, 1, 64'hffff_ffff_ffff_fff0, 0);
        add_vec("lbu_off0", 1, 0, 3'd4, 64'h8000_0010, 64'h0, 1, 64'h87, 0);
        add_vec("lbu_off1", 1, 0, 3'd4, 64'h8000_0011, 64'h0, 1, 64'h96, 0);
        add_vec("lbu_off2", 1, 0, 3'd4, 64'h8000_0012, 64'h0, 1, 64'ha5, 0);
        add_vec("lbu_off3", 1, 0, 3'd4, 64'h8000_0013, 64'h0, 1, 64'hb4, 0);
        add_vec("lbu_off4", 1, 0, 3'd4, 64'h8000_0014, 64'h0, 1, 64'hc3, 0);
        add_vec("lbu_off5", 1, 0, 3'd4, 64'h8000_0015, 64'h0, 1, 64'hd2, 0);
        add_vec("lbu_off6", 1, 0, 3'd4, 64'h8000_0016, 64'h0, 1, 64'he1, 0);
        add_vec("lbu_off7", 1, 0, 3'd4, 64'h8000_0017, 64'h0, 1, 64'hf0, 0);
        add_vec("lh_off0", 1, 0, 3'd1, 64'h8000_0010, 64'h0, 1, 64'hffff_ffff_ffff_9687, 0);
        add_vec("lh_off2", 1, 0, 3'd1, 64'h8000_0012, 64'h0, 1, 64'hffff_ffff_ffff_b4a5, 0);
        add_vec("lh_off4", 1, 0, 3'd1, 64'h8000_0014, 64'h0, 1, 64'hffff_ffff_ffff_d2c3, 0);
        add_vec("lh_off6", 1, 0, 3'd1, 64'h8000_0016, 64'h0, 1, 64'hffff_ffff_ffff_f0e1, 0);
        add_vec("lhu_off0", 1, 0, 3'd5, 64'h8000_0010, 64'h0, 1, 64'h9687, 0);
        add_vec("lhu_off2", 1, 0, 3'd5, 64'h8000_0012, 64'h0, 1, 64'hb4a5, 0);
        add_vec("lhu_off4", 1, 0, 3'd5, 64'h8000_0014, 64'h0, 1, 64'hd2c3, 0);
        add_vec("lhu_off6", 1, 0, 3'd5, 64'h8000_0016, 64'h0, 1, 64'hf0e1, 0);
        add_vec("lw_off0", 1, 0, 3'd2, 64'h8000_0010, 64'h0, 1, 64'hffff_ffff_b4a5_9687, 0);
        add_vec("lw_off4", 1, 0, 3'd2, 64'h8000_0014, 64'h0, 1, 64'hffff_ffff_f0e1_d2c3, 0);
        add_vec("lwu_off0", 1, 0, 3'd6, 64'h8000_0010, 64'h0, 1, 64'hb4a5_9687, 0);
        add_vec("lwu_off4", 1, 0, 3'd6, 64'h8000_0014, 64'h0, 1, 64'hf0e1_d2c3, 0);
        // misaligned requests fault and do nothing else
        add_vec("lh_mis", 1, 0, 3'd1, 64'h8000_0011, 64'h0, 0, 64'h0, 1);
        add_vec("lw_mis", 1, 0, 3'd2, 64'h8000_0012, 64'h0, 0, 64'h0, 1);
        add_vec("ld_mis", 1, 0, 3'd3, 64'h8000_0014, 64'h0, 0, 64'h0, 1);
        add_vec("sd_mis", 0, 1, 3'd3, 64'h8000_0004, 64'hffff_ffff_ffff_ffff, 0, 64'h0, 1);
        add_vec("sw_mis", 0, 1, 3'd2, 64'h8000_0002, 64'hffff_ffff, 0, 64'h0, 1);
        add_vec("sh_mis", 0, 1, 3'd1, 64'h8000_0009, 64'hffff, 0, 64'h0, 1);
        // back to back reads show the misaligned stores left no trace
        add_vec("ld_row0_b2b", 1, 0, 3'd3, 64'h8000_0000, 64'h0, 1, 64'h0123_4567_89ab_cdef, 0);
        add_vec("ld_row1_b2b", 1, 0, 3'd3, 64'h8000_0008, 64'h0, 1, 64'hbeef_3344_55aa_7788, 0);
        add_vec("ld_row2_b2b", 1, 0, 3'd3, 64'h8000_0010, 64'h0, 1, 64'hf0e1_d2c3_b4a5_9687, 0);
        // ren with wen acts as a write only
        add_vec("rw_both", 1, 1, 3'd3, 64'h8000_0018, 64'h5a5a_5a5a_a5a5_a5a5, 0, 64'h0, 0);
        add_vec("ld_row3", 1, 0, 3'd3, 64'h8000_0018, 64'h0, 1, 64'h5a5a_5a5a_a5a5_a5a5, 0);
    endtask

`endif

//--- sim/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

    localparam addr_t ram_base = 64'h8000_0000;
    localparam int ram_bytes = 512;
    localparam int random_count = 400;

    typedef struct packed {
        logic ren;
        logic wen;
        funct3_t funct3;
        addr_t addr;
        data_t wdata;
        logic rvalid;
        data_t rdata;
        logic fault;
    } vector_t;

    logic clk;
    logic reset;
    logic ren;
    logic wen;
    addr_t addr;
    data_t wdata;
    funct3_t funct3;
    data_t rdata;
    logic rvalid;
    logic fault;

    vector_t vectors[$];
    string vector_names[$];
    logic [7:0] ref_mem [0:ram_bytes-1];
    logic [31:0] seed = 32'hb6bf;
    int cycle_count = 0;
    int timeout_limit;

    // what the DUT must show one cycle after the last drive
    string pend_name;
    logic pend_active;
    logic pend_rvalid;
    data_t pend_rdata;
    logic pend_fault;

    lsu_top lsu_top_inst (
        .clk(clk),
        .reset(reset),
        .ren(ren),
        .wen(wen),
        .addr(addr),
        .wdata(wdata),
        .funct3(funct3),
        .rdata(rdata),
        .rvalid(rvalid),
        .fault(fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the test did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // checks the previous cycle, then drives the next request
    task automatic apply_cycle(input string name, input logic rd, input logic wr,
                               input funct3_t f3, input addr_t a, input data_t wd,
                               input logic exp_rvalid, input data_t exp_rdata,
                               input logic exp_fault);
        @(posedge clk);
        #10;
        if (pend_active) begin
            check({pend_name, " rvalid"}, data_t'(pend_rvalid), data_t'(rvalid));
            check({pend_name, " fault"}, data_t'(pend_fault), data_t'(fault));
            if (pend_rvalid) begin
                check({pend_name, " rdata"}, pend_rdata, rdata);
            end
        end
        ren = rd;
        wen = wr;
        funct3 = f3;
        addr = a;
        wdata = wd;
        pend_name = name;
        pend_rvalid = exp_rvalid;
        pend_rdata = exp_rdata;
        pend_fault = exp_fault;
        pend_active = 1'b1;
    endtask

    task automatic add_vec(input string name, input int rd, input int wr, input funct3_t f3,
                           input addr_t a, input data_t wd, input int exp_rvalid,
                           input data_t exp_rdata, input int exp_fault);
        vector_t v;
        v.ren = (rd != 0);
        v.wen = (wr != 0);
        v.funct3 = f3;
        v.addr = a;
        v.wdata = wd;
        v.rvalid = (exp_rvalid != 0);
        v.rdata = exp_rdata;
        v.fault = (exp_fault != 0);
        vectors.push_back(v);
        vector_names.push_back(name);
    endtask

`include "lsu_tb_vectors.svh"

    // field from the byte model, extended by the funct3 rules
    function automatic data_t ref_read(input int idx, input int nbytes, input logic is_unsigned);
        data_t value;
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = ref_mem[idx + i];
        end
        if (!is_unsigned && nbytes < 8 && value[nbytes*8-1]) begin
            for (int i = nbytes * 8; i < 64; i++) begin
                value[i] = 1'b1;
            end
        end
        return value;
    endfunction

    task automatic random_cycle(input int n);
        logic [31:0] r;
        int kind;
        int nbytes;
        int rel;
        logic rd;
        logic wr;
        funct3_t f3;
        data_t wd;
        logic exp_rvalid;
        data_t exp_rdata;
        logic exp_fault;
        r = next_random();
        kind = int'(r[18:16]);
        rd = (kind < 3) || (kind == 6);
        wr = (kind >= 3) && (kind <= 6);
        f3 = r[22:20];
        if (wr) begin
            f3[2] = 1'b0;
        end
        nbytes = 1 << f3[1:0];
        rel = int'(next_random() >> 16) % ram_bytes;
        // about half the requests are forced aligned
        if (r[24]) begin
            rel = rel - (rel % nbytes);
        end
        wd = {next_random(), next_random()};
        exp_rvalid = 1'b0;
        exp_rdata = '0;
        exp_fault = 1'b0;
        if ((rd || wr) && (rel % nbytes) != 0) begin
            exp_fault = 1'b1;
        end else if (wr) begin
            for (int i = 0; i < nbytes; i++) begin
                ref_mem[rel + i] = wd[i*8 +: 8];
            end
        end else if (rd) begin
            exp_rvalid = 1'b1;
            exp_rdata = ref_read(rel, nbytes, f3[2]);
        end
        apply_cycle($sformatf("random_%0d", n), rd, wr, f3, ram_base + addr_t'(rel), wd,
                    exp_rvalid, exp_rdata, exp_fault);
    endtask

    initial begin
        data_t fill_data;
        reset = 1'b1;
        // an aligned double read is held while reset is high
        ren = 1'b1;
        wen = 1'b0;
        addr = ram_base;
        wdata = '0;
        funct3 = 3'd3;
        pend_active = 1'b0;
        fill_vectors();
        timeout_limit = 16 + vectors.size() + ram_bytes / 8 + random_count + 20;
        repeat (15) @(posedge clk);
        #10;
        check("reset_rvalid", '0, data_t'(rvalid));
        // misaligned read in the last reset cycle
        addr = ram_base + 64'd4;
        @(posedge clk);
        #10;
        check("reset_fault", '0, data_t'(fault));
        reset = 1'b0;
        ren = 1'b0;
        addr = '0;
        funct3 = '0;
        // status outputs must be low right after reset
        pend_name = "after_reset";
        pend_rvalid = 1'b0;
        pend_fault = 1'b0;
        pend_active = 1'b1;

        for (int i = 0; i < vectors.size(); i++) begin
            apply_cycle(vector_names[i], vectors[i].ren, vectors[i].wen, vectors[i].funct3,
                        vectors[i].addr, vectors[i].wdata, vectors[i].rvalid,
                        vectors[i].rdata, vectors[i].fault);
        end

        // known contents everywhere before random traffic
        for (int row = 0; row < ram_bytes / 8; row++) begin
            fill_data = {next_random(), next_random()};
            for (int i = 0; i < 8; i++) begin
                ref_mem[row*8 + i] = fill_data[i*8 +: 8];
            end
            apply_cycle($sformatf("fill_%0d", row), 1'b0, 1'b1, 3'd3,
                        ram_base + addr_t'(row * 8), fill_data, 1'b0, '0, 1'b0);
        end

        for (int n = 0; n < random_count; n++) begin
            random_cycle(n);
        end

        repeat (2) apply_cycle("drain", 1'b0, 1'b0, 3'd0, '0, '0, 1'b0, '0, 1'b0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+sim
design/lsu_pkg.sv
design/mem_req_if.sv
design/mem_rsp_if.sv
design/lsu_decode.sv
design/lsu_ram.sv
design/lsu_load_align.sv
design/lsu_top.sv
sim/lsu_tb.sv

//--- Makefile
SOURCES := $(wildcard design/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vlsu_tb: sim.f $(SOURCES)
	verilator --binary --timing --top-module lsu_tb -f sim.f

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
